//--- src/serdes_pkg.sv
// shared widths and lane word structs for the serdes link fabric, referenced by scoped name
`default_nettype none

package serdes_pkg;

  // byte and pattern counter geometry
  localparam int data_bits     = 8;   // one tx or rx byte
  localparam int pat_hold_bits = 8;   // low counter bits, one data value lasts 256 cycles
  localparam int pat_bits      = data_bits + pat_hold_bits;

  // blink and edge counters, shortened for simulation
  localparam int hb_bits      = 10;   // hardware build would use 28
  localparam int ldr_cnt_bits = 6;    // hardware build would use 20

  localparam int num_lanes = 2;       // rx lanes on the dual
  localparam int led_bits  = 8;       // board leds
  localparam int half_bits = data_bits / 2;  // folded byte width on the leds

  // word handed to the tx lanes
  typedef struct packed {
    logic [data_bits-1:0] data;
    logic                 comma;      // k flag, tx bit 8 on the dcu
  } tx_word_t;

  // raw word from one rx lane
  typedef struct packed {
    logic [data_bits-1:0] data;
    logic                 los;        // loss of signal
    logic                 lol;        // cdr loss of lock
    logic                 ldr;        // low speed serial input
  } rx_lane_t;

  // per lane status shown on the leds
  typedef struct packed {
    logic [data_bits-1:0] data;       // registered byte
    logic                 los;
    logic                 lol;
    logic                 hb;         // heartbeat msb
    logic                 ldr_msb;    // edge counter msb
  } lane_status_t;

endpackage

`default_nettype wire

//--- src/pattern_gen.sv
// tx test pattern source driving a free running counter byte with a comma flag to the top
`timescale 1ns/1ps
`default_nettype none

module pattern_gen (
  input  wire                  rx0_pclk,
  input  wire                  rst_n,
  output serdes_pkg::tx_word_t tx
);

  logic [serdes_pkg::pat_bits-1:0] cnt;      // pattern counter
  logic                            comma_q;  // registered comma flag
  logic                            wrap;     // last cycle of a data value

  // low bits all ones means the upper byte steps on the next edge
  assign wrap = &cnt[serdes_pkg::pat_hold_bits-1:0];

  always_ff @(posedge rx0_pclk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      cnt     <= '0;
      comma_q <= 1'b0;
    end
    else
    begin
      cnt     <= cnt + 1'b1;  // free running and wraps silently
      comma_q <= wrap;        // lines up with the first cycle of the new byte
    end
  end

  // upper counter byte goes out while low bits only set the hold time
  assign tx = '{
    data:  cnt[serdes_pkg::pat_bits-1:serdes_pkg::pat_hold_bits],
    comma: comma_q
  };

  // a comma must mark a byte change and never a repeated value
  a_comma_on_step : assert property (
    @(posedge rx0_pclk) disable iff (!rst_n)
    tx.comma |-> (tx.data != $past(tx.data))
  );

endmodule

`default_nettype wire

//--- src/lane_monitor.sv
// rx lane monitor that registers byte and flags and counts heartbeat and ldr edges for each lane
`timescale 1ns/1ps
`default_nettype none

module lane_monitor (
  input  wire                      rx0_pclk,
  input  wire                      rst_n,
  input  serdes_pkg::rx_lane_t     rx,
  output serdes_pkg::lane_status_t status
);

  // registered copy of the lane word
  logic [serdes_pkg::data_bits-1:0] data_q;
  logic                             los_q;
  logic                             lol_q;

  // blink counter
  logic [serdes_pkg::hb_bits-1:0] hb_cnt;

  // ldr edge detection
  logic [1:0]                          ldr_trk;   // [1] newest sample and [0] previous
  logic                                ldr_rise;  // tracker shows 0 then 1
  logic [serdes_pkg::ldr_cnt_bits-1:0] ldr_cnt;   // rising edges seen

  // lane word and flags with one cycle of latency
  always_ff @(posedge rx0_pclk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      data_q <= '0;
      los_q  <= 1'b0;
      lol_q  <= 1'b0;
    end
    else
    begin
      data_q <= rx.data;
      los_q  <= rx.los;   // signal lost on the wire
      lol_q  <= rx.lol;   // cdr not locked
    end
  end

  // heartbeat msb toggles every 2^(hb_bits-1) cycles
  always_ff @(posedge rx0_pclk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      hb_cnt <= '0;
    end
    else
    begin
      hb_cnt <= hb_cnt + 1'b1;
    end
  end

  // two stage tracker with the new sample shifting in at the top
  always_ff @(posedge rx0_pclk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      ldr_trk <= 2'b00;
    end
    else
    begin
      ldr_trk <= {rx.ldr, ldr_trk[1]};
    end
  end

  assign ldr_rise = (ldr_trk == 2'b10);  // high now and low one cycle before

  // edge counter steps two cycles after the ldr rise
  always_ff @(posedge rx0_pclk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      ldr_cnt <= '0;
    end
    else if (ldr_rise)
    begin
      ldr_cnt <= ldr_cnt + 1'b1;
    end
  end

  // status word toward the display
  assign status = '{
    data:    data_q,
    los:     los_q,
    lol:     lol_q,
    hb:      hb_cnt[serdes_pkg::hb_bits-1],
    ldr_msb: ldr_cnt[serdes_pkg::ldr_cnt_bits-1]
  };

  // counter moves only after a detected rise and by exactly one
  a_ldr_cnt_step : assert property (
    @(posedge rx0_pclk) disable iff (!rst_n)
    (ldr_cnt != $past(ldr_cnt)) |->
      ($past(ldr_rise) && (ldr_cnt == $past(ldr_cnt) + 1'b1))
  );

endmodule

`default_nettype wire

//--- src/status_display.sv
// led status display, syncs the lane button and shows the folded byte plus lane flags
`timescale 1ns/1ps
`default_nettype none

module status_display (
  input  wire                                                     rx0_pclk,
  input  wire                                                     rst_n,
  input  serdes_pkg::lane_status_t [serdes_pkg::num_lanes-1:0] lane_status,
  input  wire                                                     lane_sel,
  output logic [serdes_pkg::led_bits-1:0]                         led
);

  logic                     sel_meta;  // first sync stage, may go metastable
  logic                     sel_q;     // synced lane select
  serdes_pkg::lane_status_t cur;       // selected lane status

  // button comes from the pad, two flops before use
  always_ff @(posedge rx0_pclk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      sel_meta <= 1'b0;
      sel_q    <= 1'b0;
    end
    else
    begin
      sel_meta <= lane_sel;
      sel_q    <= sel_meta;
    end
  end

  assign cur = lane_status[sel_q];

  // upper nibble is the or of both byte halves, lower nibble the flags
  always_ff @(posedge rx0_pclk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      led <= '0;
    end
    else
    begin
      led <= {cur.data[serdes_pkg::data_bits-1:serdes_pkg::half_bits]
                | cur.data[serdes_pkg::half_bits-1:0],
              cur.los, cur.lol, cur.hb, cur.ldr_msb};
    end
  end

  // led stays dark for the first two cycles out of reset, monitors start cleared too
  a_led_dark_after_reset : assert property (
    @(posedge rx0_pclk) disable iff (!rst_n)
    $rose(rst_n) |-> (led == '0) ##1 (led == '0)
  );

endmodule

`default_nettype wire

//--- src/serdes_link_top.sv
// serdes link fabric top, pattern source for tx, two rx lane monitors and the led display
`timescale 1ns/1ps
`default_nettype none

module serdes_link_top (
  input  wire                                                 rx0_pclk,
  input  wire                                                 rst_n,
  input  serdes_pkg::rx_lane_t [serdes_pkg::num_lanes-1:0] rx_lanes,
  input  wire                                                 lane_sel,
  output serdes_pkg::tx_word_t                                tx,
  output logic [serdes_pkg::led_bits-1:0]                     led
);

  // per lane status, one entry per monitor
  serdes_pkg::lane_status_t [serdes_pkg::num_lanes-1:0] lane_status;

  // tx word, same on every tx lane
  pattern_gen pattern_gen_i (
    .rx0_pclk (rx0_pclk),
    .rst_n    (rst_n),
    .tx       (tx)
  );

  // one monitor per rx lane
  genvar g;
  generate
    for (g = 0; g < serdes_pkg::num_lanes; g++)
    begin : g_lane
      lane_monitor lane_monitor_i (
        .rx0_pclk (rx0_pclk),
        .rst_n    (rst_n),
        .rx       (rx_lanes[g]),
        .status   (lane_status[g])
      );
    end
  endgenerate

  // button picks which lane lands on the leds
  status_display status_display_i (
    .rx0_pclk    (rx0_pclk),
    .rst_n       (rst_n),
    .lane_status (lane_status),
    .lane_sel    (lane_sel),
    .led         (led)
  );

endmodule

`default_nettype wire

//--- tb/tb_checks.svh
// testbench helpers for lfsr stimulus, led waits and typed compares included in the testbench
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

  // 32 bit fibonacci lfsr with taps 32 22 2 1 and one step per bit taken
  function automatic logic lfsr_bit();
    logic fb;
    fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
    lfsr_state = {lfsr_state[30:0], fb};
    return fb;
  endfunction

  function automatic logic [serdes_pkg::data_bits-1:0] rand_byte();
    logic [serdes_pkg::data_bits-1:0] b;
    b = '0;
    for (int i = 0; i < serdes_pkg::data_bits; i++)
    begin
      b = {b[serdes_pkg::data_bits-2:0], lfsr_bit()};  // eight steps per byte
    end
    return b;
  endfunction

  // whole tx word compared as one struct
  task automatic compare_tx(input string name, input serdes_pkg::tx_word_t got,
                            input serdes_pkg::tx_word_t exp);
    if (got !== exp)
    begin
      $display("MISMATCH %s got %h expected %h at cycle %0d", name, got, exp, cyc);
      fail_stop("tx word differs from the expected pattern");
    end
  endtask

  // led compare over the bits set in mask
  task automatic compare_led(input string name, input logic [serdes_pkg::led_bits-1:0] got,
                             input logic [serdes_pkg::led_bits-1:0] exp,
                             input logic [serdes_pkg::led_bits-1:0] mask);
    if ((got & mask) !== (exp & mask))
    begin
      $display("MISMATCH %s got %h expected %h mask %h at cycle %0d",
               name, got & mask, exp & mask, mask, cyc);
      fail_stop("led value differs from the expected value");
    end
  endtask

  // poll led on falling edges until the masked bits match
  task automatic wait_led(input logic [serdes_pkg::led_bits-1:0] exp,
                          input logic [serdes_pkg::led_bits-1:0] mask,
                          input int max_cycles, input string what);
    int n;
    n = 0;
    while ((led & mask) !== (exp & mask))
    begin
      if (n >= max_cycles)
        fail_stop($sformatf("led never showed %s within %0d cycles", what, max_cycles));
      else
      begin
        @(negedge rx0_pclk);
        n++;
      end
    end
  endtask

`endif

//--- tb/tb_serdes_link.sv
// testbench for the serdes link fabric, loops tx back to lane 0 and runs directed checks on led
`timescale 1ns/1ps
`default_nettype none

module tb_serdes_link;

  logic                                                  rx0_pclk;
  logic                                                  rst_n;
  serdes_pkg::rx_lane_t [serdes_pkg::num_lanes-1:0]      rx_lanes;
  logic                                                  lane_sel;
  serdes_pkg::tx_word_t                                  tx;
  logic [serdes_pkg::led_bits-1:0]                       led;

  // values the drive process puts on the dut at the next rising edge
  logic                  drv_rst_n = 1'b0;
  logic                  drv_sel   = 1'b0;
  logic                  loop_en   = 1'b1;   // lane 0 data follows tx.data
  serdes_pkg::rx_lane_t  drv_lane0 = '0;
  serdes_pkg::rx_lane_t  drv_lane1 = '0;

  logic [31:0]  lfsr_state = 32'hfcd0;
  int unsigned  cyc = 0;                     // active edges since reset release

  serdes_link_top serdes_link_top_i (
    .rx0_pclk (rx0_pclk),
    .rst_n    (rst_n),
    .rx_lanes (rx_lanes),
    .lane_sel (lane_sel),
    .tx       (tx),
    .led      (led)
  );

  task automatic fail_stop(input string why);
    $display("%s", why);
    $display("TB FAILED");
    $fatal(1, "stopping at the first error");
  endtask

`include "tb_checks.svh"

  initial
  begin
    rx0_pclk = 1'b0;
    forever #5 rx0_pclk = ~rx0_pclk;
  end

  // single driver for every dut input
  initial
  begin
    rst_n    = 1'b0;
    lane_sel = 1'b0;
    rx_lanes = '0;
    forever
    begin
      @(posedge rx0_pclk);
      rst_n            <= drv_rst_n;
      lane_sel         <= drv_sel;
      rx_lanes[1]      <= drv_lane1;
      rx_lanes[0].los  <= drv_lane0.los;
      rx_lanes[0].lol  <= drv_lane0.lol;
      rx_lanes[0].ldr  <= drv_lane0.ldr;
      rx_lanes[0].data <= loop_en ? tx.data : drv_lane0.data;  // loopback
    end
  end

  always @(posedge rx0_pclk)
    if (rst_n)
      cyc <= cyc + 1;

  // tx word expected at counter value c with a comma on each new value but the first
  function automatic serdes_pkg::tx_word_t tx_expect(input int unsigned c);
    serdes_pkg::tx_word_t w;
    logic [31:0]          v;
    v       = c >> serdes_pkg::pat_hold_bits;  // counter upper bits
    w.data  = v[serdes_pkg::data_bits-1:0];
    w.comma = (c % (1 << serdes_pkg::pat_hold_bits) == 0) && (c != 0);
    return w;
  endfunction

  function automatic logic [3:0] fold(input logic [serdes_pkg::data_bits-1:0] d);
    return d[7:4] | d[3:0];
  endfunction

  task automatic reset_test();
    int n;
    repeat (3)
    begin
      @(negedge rx0_pclk);
      compare_led("led in reset", led, 8'h00, 8'hff);
      compare_tx("tx in reset", tx, '0);
    end
    drv_rst_n = 1'b1;  // rises on the fourth edge
    n = 0;
    while (cyc < 2)
    begin
      if (n > 4)
        fail_stop("cycle count did not start after reset release");
      else
      begin
        @(negedge rx0_pclk);
        n++;
      end
    end
    compare_led("led after reset", led, 8'h00, 8'hff);
    compare_tx("tx after reset", tx, '0);
  endtask

  task automatic heartbeat_test();
    int          n;
    logic        b;
    int unsigned half;
    half = 1 << (serdes_pkg::hb_bits - 1);
    n = 0;
    while (cyc <= half + 1)
    begin
      b = (cyc > half);  // hb rises after half cycles and led follows one edge later
      compare_led("led[1] heartbeat", led, {6'b0, b, 1'b0}, 8'h02);
      compare_tx("tx", tx, tx_expect(cyc));  // first data value carries no comma
      if (n > half + 20)
        fail_stop("heartbeat window never reached its end");
      else
      begin
        @(negedge rx0_pclk);
        n++;
      end
    end
  endtask

  task automatic pattern_test();
    int                               n;
    logic [31:0]                      step;
    logic [serdes_pkg::data_bits-1:0] start;
    serdes_pkg::tx_word_t             exp;
    n = 0;
    while (tx.comma !== 1'b1)
    begin
      if (n > 300)
        fail_stop("no comma seen on tx within one data period");
      else
      begin
        @(negedge rx0_pclk);
        n++;
      end
    end
    step  = cyc >> serdes_pkg::pat_hold_bits;  // data value that begins on this cycle
    start = step[serdes_pkg::data_bits-1:0];
    for (int i = 0; i < 3 * 256; i++)
    begin
      step      = start + i / 256;  // one step every 256 cycles
      exp.data  = step[serdes_pkg::data_bits-1:0];
      exp.comma = (i % 256 == 0);
      compare_tx("tx pattern", tx, exp);
      @(negedge rx0_pclk);
    end
  endtask

  task automatic fold_test();
    logic [serdes_pkg::data_bits-1:0] hist[$];
    logic [serdes_pkg::data_bits-1:0] d;
    for (int i = 0; i < 60; i++)
    begin
      loop_en        = (i < 20);  // looped bytes before lfsr bytes
      drv_lane0.data = rand_byte();
      drv_lane1.data = rand_byte();
      hist.push_back(rx_lanes[0].data);
      if (hist.size() > 2)
      begin
        d = hist.pop_front();
        compare_led("led fold lane 0", led, {fold(d), 4'b0000}, 8'hfc);
      end
      @(negedge rx0_pclk);
    end
  endtask

  task automatic lane_sel_test();
    drv_lane0      = '{data: rand_byte(), los: 1'b0, lol: 1'b0, ldr: 1'b0};
    drv_lane1      = '{data: rand_byte(), los: 1'b1, lol: 1'b0, ldr: 1'b0};
    repeat (3) @(negedge rx0_pclk);
    drv_sel = 1'b1;
    wait_led({fold(drv_lane1.data), 4'b1000}, 8'hfc, 4, "lane 1 status");
    drv_sel = 1'b0;
    wait_led({fold(drv_lane0.data), 4'b0000}, 8'hfc, 4, "lane 0 status");
  endtask

  task automatic edge_test();
    int edges;
    edges = 1 << (serdes_pkg::ldr_cnt_bits - 1);
    for (int i = 0; i < edges - 1; i++)
    begin
      drv_lane0.ldr = 1'b1;
      repeat (2) @(negedge rx0_pclk);
      drv_lane0.ldr = 1'b0;
      repeat (2) @(negedge rx0_pclk);
      compare_led("led[0] before last edge", led, 8'h00, 8'h01);
    end
    repeat (3)
    begin
      @(negedge rx0_pclk);
      compare_led("led[0] before last edge", led, 8'h00, 8'h01);
    end
    drv_lane0.ldr = 1'b1;  // last rising edge
    wait_led(8'h01, 8'h01, 4, "the edge counter msb");
  endtask

  initial
  begin
    reset_test();
    heartbeat_test();
    pattern_test();
    fold_test();
    lane_sel_test();
    edge_test();
    $display("TB PASSED");
    $finish;
  end

endmodule

`default_nettype wire

//--- flist.f
+incdir+tb
src/serdes_pkg.sv
src/pattern_gen.sv
src/lane_monitor.sv
src/status_display.sv
src/serdes_link_top.sv
tb/tb_serdes_link.sv

//--- Makefile
SIM   ?= verilator
FLAGS ?= --binary --timing --assert -j 0
TOP   ?= tb_serdes_link
FLIST ?= flist.f
BUILD ?= obj_dir

SRCS := $(wildcard src/*.sv) $(wildcard tb/*.sv) $(wildcard tb/*.svh)
BIN  := $(BUILD)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FLIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD)

run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TB PASSED"

clean:
	rm -rf $(BUILD)
